//--- Bender.yml
package:
  name: exec_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/exec_ops_pkg.sv
      - rtl/instr_fields_pkg.sv
      - rtl/barrel_shifter.sv
      - rtl/int_alu.sv
      - rtl/mul_unit.sv
      - rtl/cond_flags_gen.sv
      - rtl/alu_block.sv
      - rtl/exec_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/exec_stage_tb.sv

//--- exec_stage.f
+incdir+rtl
rtl/exec_ops_pkg.sv
rtl/instr_fields_pkg.sv
rtl/barrel_shifter.sv
rtl/int_alu.sv
rtl/mul_unit.sv
rtl/cond_flags_gen.sv
rtl/alu_block.sv
rtl/exec_stage.sv
verification/exec_stage_tb.sv

//--- rtl/alu_block.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module alu_block (
    input  logic [`EXEC_XLEN-1:0]          in1,
    input  logic [`EXEC_XLEN-1:0]          in2,
    input  logic [`EXEC_XLEN-1:0]          in3,
    input  logic [`EXEC_XLEN-1:0]          in4,
    input  logic [`EXEC_XLEN-1:0]          ext_imm,
    input  instr_fields_pkg::shift_field_u instr_11_4,
    input  logic                           alu_src,
    input  logic                           carry,
    input  logic                           swap,
    input  logic                           inv,
    input  logic                           not_shift,
    input  exec_ops_pkg::result_src_e      result_src,
    input  exec_ops_pkg::alu_op_e          alu_op,
    input  logic                           mul_en,
    input  exec_ops_pkg::mul_cmd_e         mul_cmd,
    output logic [3:0]                     cond_flags,
    output logic [`EXEC_XLEN-1:0]          out1,
    output logic [`EXEC_XLEN-1:0]          out2
);

    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic [`EXEC_XLEN-1:0]    shifted;
    logic                     shift_carry;
    logic [`EXEC_XLEN-1:0]    op_b;
    logic [`EXEC_XLEN-1:0]    src_a;
    logic [`EXEC_XLEN-1:0]    pre_src_b;
    logic [`EXEC_XLEN-1:0]    src_b;
    logic [`EXEC_XLEN-1:0]    alu_result;
    logic                     alu_c;
    logic                     alu_v;
    logic [`EXEC_XLEN-1:0]    res_mux;
    logic [`EXEC_XLEN-1:0]    mul_lo;
    logic [`EXEC_XLEN-1:0]    mul_hi;
    logic                     arith;

    // Only the low byte of rs counts as a shift amount.
    assign shamt = instr_11_4.reg_form.reg_flag ? in4[`EXEC_SHAMT_W-1:0]
                                                : `EXEC_SHAMT_W'(instr_11_4.imm_form.amount);

    barrel_shifter shifter_inst (
        .field     (instr_11_4),
        .shamt     (shamt),
        .not_shift (not_shift),
        .carry     (carry),
        .x         (in2),
        .y         (shifted),
        .c         (shift_carry)
    );

    assign op_b      = alu_src ? ext_imm : shifted;
    assign src_a     = swap ? op_b : in1;
    assign pre_src_b = swap ? in1 : op_b;
    // Inverting with carry-in 1 gives SUB and RSB.
    assign src_b     = inv ? ~pre_src_b : pre_src_b;

    int_alu alu_inst (
        .a      (src_a),
        .b      (src_b),
        .alu_op (alu_op),
        .carry  (carry),
        .result (alu_result),
        .c      (alu_c),
        .v      (alu_v)
    );

    always_comb begin
        case (result_src)
            exec_ops_pkg::RES_ALU:   res_mux = alu_result;
            exec_ops_pkg::RES_SRC_B: res_mux = src_b;
            default:                 res_mux = in1;
        endcase
    end

    mul_unit mul_inst (
        .a      (in2),
        .b      (in4),
        .acc_lo (in1),
        .acc_hi (in3),
        .cmd    (mul_cmd),
        .lo     (mul_lo),
        .hi     (mul_hi)
    );

    assign out1 = mul_en ? mul_lo : res_mux;
    assign out2 = mul_en ? mul_hi : alu_result;

    assign arith = (result_src == exec_ops_pkg::RES_ALU) &&
                   ((alu_op == exec_ops_pkg::ALU_ADD) ||
                    (alu_op == exec_ops_pkg::ALU_ADD_ONE) ||
                    (alu_op == exec_ops_pkg::ALU_ADC));

    cond_flags_gen flags_inst (
        .res_lo  (out1),
        .res_hi  (out2),
        .alu_c   (alu_c),
        .alu_v   (alu_v),
        .shift_c (shift_carry),
        .arith   (arith),
        .mul_en  (mul_en),
        .mul_cmd (mul_cmd),
        .flags   (cond_flags)
    );

endmodule

//--- rtl/barrel_shifter.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module barrel_shifter (
    input  instr_fields_pkg::shift_field_u field,
    input  logic [`EXEC_SHAMT_W-1:0]       shamt,
    input  logic                           not_shift,
    input  logic                           carry,
    input  logic [`EXEC_XLEN-1:0]          x,
    output logic [`EXEC_XLEN-1:0]          y,
    output logic                           c
);

    exec_ops_pkg::shift_type_e sh_type;
    logic                      reg_form;
    logic [`EXEC_SHAMT_W-1:0]  amt;
    logic [`EXEC_XLEN:0]       lsl_w;
    logic [`EXEC_XLEN:0]       lsr_w;
    logic [`EXEC_XLEN:0]       asr_w;
    logic [2*`EXEC_XLEN-1:0]   ror_w;

    assign reg_form = field.reg_form.reg_flag;
    assign sh_type  = field.imm_form.sh_type;

    // Immediate LSR #0 and ASR #0 encode a shift by 32.
    always_comb begin
        amt = shamt;
        if (!reg_form && shamt == '0 &&
            (sh_type == exec_ops_pkg::SH_LSR || sh_type == exec_ops_pkg::SH_ASR)) begin
            amt = `EXEC_SHAMT_W'(`EXEC_XLEN);
        end
    end

    // One extra bit catches the last bit shifted out.
    assign lsl_w = {1'b0, x} << amt;
    assign lsr_w = {x, 1'b0} >> amt;
    assign asr_w = $signed({x, 1'b0}) >>> amt;
    assign ror_w = {x, x} >> amt[4:0];

    always_comb begin
        y = x;
        c = carry;
        if (!not_shift) begin
            if (amt == '0) begin
                // RRX.
                if (!reg_form && sh_type == exec_ops_pkg::SH_ROR) begin
                    y = {carry, x[`EXEC_XLEN-1:1]};
                    c = x[0];
                end
            end else begin
                case (sh_type)
                    exec_ops_pkg::SH_LSL: {c, y} = lsl_w;
                    exec_ops_pkg::SH_LSR: {y, c} = lsr_w;
                    exec_ops_pkg::SH_ASR: {y, c} = asr_w;
                    default: begin
                        y = ror_w[`EXEC_XLEN-1:0];
                        c = ror_w[`EXEC_XLEN-1];
                    end
                endcase
            end
        end
    end

endmodule

//--- rtl/cond_flags_gen.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module cond_flags_gen (
    input  logic [`EXEC_XLEN-1:0]  res_lo,
    input  logic [`EXEC_XLEN-1:0]  res_hi,
    input  logic                   alu_c,
    input  logic                   alu_v,
    input  logic                   shift_c,
    input  logic                   arith,
    input  logic                   mul_en,
    input  exec_ops_pkg::mul_cmd_e mul_cmd,
    output logic [3:0]             flags
);

    logic long_mul;
    logic n;
    logic z;
    logic c;
    logic v;

    assign long_mul = (mul_cmd == exec_ops_pkg::MUL_UMULL) ||
                      (mul_cmd == exec_ops_pkg::MUL_UMLAL) ||
                      (mul_cmd == exec_ops_pkg::MUL_SMULL) ||
                      (mul_cmd == exec_ops_pkg::MUL_SMLAL);

    always_comb begin
        n = res_lo[`EXEC_XLEN-1];
        z = (res_lo == '0);
        c = shift_c;
        v = 1'b0;
        if (mul_en) begin
            // Long multiplies test the full 64-bit result.
            if (long_mul) begin
                n = res_hi[`EXEC_XLEN-1];
                z = ({res_hi, res_lo} == '0);
            end
            c = 1'b0;
        end else if (arith) begin
            c = alu_c;
            v = alu_v;
        end
    end

    assign flags = {n, z, c, v};

endmodule

//--- rtl/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width of the execute stage.
`define EXEC_XLEN 32

// Register-specified shift amounts use the low byte of the register.
`define EXEC_SHAMT_W 8

`endif

//--- rtl/exec_ops_pkg.sv
package exec_ops_pkg;

    // Integer ALU operation. Codes 6 and 7 give a zero result.
    typedef enum logic [2:0] {
        ALU_ADD     = 3'd0,
        ALU_ADD_ONE = 3'd1,
        ALU_ADC     = 3'd2,
        ALU_AND     = 3'd3,
        ALU_ORR     = 3'd4,
        ALU_EOR     = 3'd5
    } alu_op_e;

    // Source of the main result word.
    typedef enum logic [1:0] {
        RES_ALU     = 2'd0,
        RES_SRC_B   = 2'd1,
        RES_IN1     = 2'd2,
        RES_IN1_ALT = 2'd3
    } result_src_e;

    // Multiply command. Codes 6 and 7 are reserved and give zero.
    typedef enum logic [2:0] {
        MUL_MUL   = 3'd0,
        MUL_MLA   = 3'd1,
        MUL_UMULL = 3'd2,
        MUL_UMLAL = 3'd3,
        MUL_SMULL = 3'd4,
        MUL_SMLAL = 3'd5
    } mul_cmd_e;

    typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
    } shift_type_e;

endpackage

//--- rtl/exec_stage.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid_in,
    input  logic [`EXEC_XLEN-1:0]          in1,
    input  logic [`EXEC_XLEN-1:0]          in2,
    input  logic [`EXEC_XLEN-1:0]          in3,
    input  logic [`EXEC_XLEN-1:0]          in4,
    input  logic [`EXEC_XLEN-1:0]          ext_imm,
    input  instr_fields_pkg::shift_field_u instr_11_4,
    input  logic                           alu_src,
    input  logic                           carry,
    input  logic                           swap,
    input  logic                           inv,
    input  logic                           not_shift,
    input  exec_ops_pkg::result_src_e      result_src,
    input  exec_ops_pkg::alu_op_e          alu_op,
    input  logic                           mul_en,
    input  exec_ops_pkg::mul_cmd_e         mul_cmd,
    output logic                           valid_out,
    output logic [`EXEC_XLEN-1:0]          result_lo,
    output logic [`EXEC_XLEN-1:0]          result_hi,
    output logic [3:0]                     flags
);

    logic [3:0]            cond_flags;
    logic [`EXEC_XLEN-1:0] out1;
    logic [`EXEC_XLEN-1:0] out2;

    alu_block alu_block_inst (
        .in1        (in1),
        .in2        (in2),
        .in3        (in3),
        .in4        (in4),
        .ext_imm    (ext_imm),
        .instr_11_4 (instr_11_4),
        .alu_src    (alu_src),
        .carry      (carry),
        .swap       (swap),
        .inv        (inv),
        .not_shift  (not_shift),
        .result_src (result_src),
        .alu_op     (alu_op),
        .mul_en     (mul_en),
        .mul_cmd    (mul_cmd),
        .cond_flags (cond_flags),
        .out1       (out1),
        .out2       (out2)
    );

    // Execute/memory pipeline register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            result_lo <= '0;
            result_hi <= '0;
            flags     <= '0;
        end else begin
            valid_out <= valid_in;
            if (valid_in) begin
                result_lo <= out1;
                result_hi <= out2;
                flags     <= cond_flags;
            end
        end
    end

endmodule

//--- rtl/instr_fields_pkg.sv
package instr_fields_pkg;

    // Instruction bits 11..4 with an immediate shift amount.
    typedef struct packed {
        logic [4:0]                amount;
        exec_ops_pkg::shift_type_e sh_type;
        logic                      reg_flag;
    } imm_shift_t;

    // Instruction bits 11..4 with the amount held in register rs.
    typedef struct packed {
        logic [3:0]                rs;
        logic                      zero;
        exec_ops_pkg::shift_type_e sh_type;
        logic                      reg_flag;
    } reg_shift_t;

    typedef union packed {
        imm_shift_t imm_form;
        reg_shift_t reg_form;
    } shift_field_u;

endpackage

//--- rtl/int_alu.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module int_alu (
    input  logic [`EXEC_XLEN-1:0] a,
    input  logic [`EXEC_XLEN-1:0] b,
    input  exec_ops_pkg::alu_op_e alu_op,
    input  logic                  carry,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  c,
    output logic                  v
);

    logic                cin;
    logic [`EXEC_XLEN:0] sum;

    always_comb begin
        case (alu_op)
            exec_ops_pkg::ALU_ADD_ONE: cin = 1'b1;
            exec_ops_pkg::ALU_ADC:     cin = carry;
            default:                   cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, a} + {1'b0, b} + {{`EXEC_XLEN{1'b0}}, cin};

    always_comb begin
        result = '0;
        c      = 1'b0;
        v      = 1'b0;
        case (alu_op)
            exec_ops_pkg::ALU_ADD, exec_ops_pkg::ALU_ADD_ONE, exec_ops_pkg::ALU_ADC: begin
                result = sum[`EXEC_XLEN-1:0];
                c      = sum[`EXEC_XLEN];
                // Same operand signs, different result sign.
                v      = (a[`EXEC_XLEN-1] == b[`EXEC_XLEN-1]) &&
                         (sum[`EXEC_XLEN-1] != a[`EXEC_XLEN-1]);
            end
            exec_ops_pkg::ALU_AND: result = a & b;
            exec_ops_pkg::ALU_ORR: result = a | b;
            exec_ops_pkg::ALU_EOR: result = a ^ b;
            default:               result = '0;
        endcase
    end

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module mul_unit (
    input  logic [`EXEC_XLEN-1:0]  a,
    input  logic [`EXEC_XLEN-1:0]  b,
    input  logic [`EXEC_XLEN-1:0]  acc_lo,
    input  logic [`EXEC_XLEN-1:0]  acc_hi,
    input  exec_ops_pkg::mul_cmd_e cmd,
    output logic [`EXEC_XLEN-1:0]  lo,
    output logic [`EXEC_XLEN-1:0]  hi
);

    logic                    is_signed;
    logic [2*`EXEC_XLEN-1:0] a_ext;
    logic [2*`EXEC_XLEN-1:0] b_ext;
    logic [2*`EXEC_XLEN-1:0] prod;
    logic [2*`EXEC_XLEN-1:0] acc;
    logic [2*`EXEC_XLEN-1:0] total;

    assign is_signed = (cmd == exec_ops_pkg::MUL_SMULL) || (cmd == exec_ops_pkg::MUL_SMLAL);

    // Sign-extending to 64 bits lets one unsigned multiplier serve both forms.
    assign a_ext = {{`EXEC_XLEN{is_signed & a[`EXEC_XLEN-1]}}, a};
    assign b_ext = {{`EXEC_XLEN{is_signed & b[`EXEC_XLEN-1]}}, b};
    assign prod  = a_ext * b_ext;

    always_comb begin
        case (cmd)
            exec_ops_pkg::MUL_MLA:   acc = {{`EXEC_XLEN{1'b0}}, acc_lo};
            exec_ops_pkg::MUL_UMLAL,
            exec_ops_pkg::MUL_SMLAL: acc = {acc_hi, acc_lo};
            default:                 acc = '0;
        endcase
    end

    assign total = prod + acc;

    always_comb begin
        lo = '0;
        hi = '0;
        case (cmd)
            exec_ops_pkg::MUL_MUL, exec_ops_pkg::MUL_MLA: begin
                lo = total[`EXEC_XLEN-1:0];
            end
            exec_ops_pkg::MUL_UMULL, exec_ops_pkg::MUL_UMLAL,
            exec_ops_pkg::MUL_SMULL, exec_ops_pkg::MUL_SMLAL: begin
                lo = total[`EXEC_XLEN-1:0];
                hi = total[2*`EXEC_XLEN-1:`EXEC_XLEN];
            end
            default: ;
        endcase
    end

endmodule

//--- verification/exec_stage_tb.sv
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_stage_tb;

    localparam int N_ALU      = 300;
    localparam int N_SHIFT    = 300;
    localparam int N_MUL      = 200;
    localparam int N_MIX      = 200;
    localparam int MAX_CYCLES = N_ALU + N_SHIFT + N_MUL + N_MIX + 20;

    logic                           clk;
    logic                           rst_n;
    logic                           valid_in;
    logic [`EXEC_XLEN-1:0]          in1;
    logic [`EXEC_XLEN-1:0]          in2;
    logic [`EXEC_XLEN-1:0]          in3;
    logic [`EXEC_XLEN-1:0]          in4;
    logic [`EXEC_XLEN-1:0]          ext_imm;
    instr_fields_pkg::shift_field_u instr_11_4;
    logic                           alu_src;
    logic                           carry;
    logic                           swap;
    logic                           inv;
    logic                           not_shift;
    exec_ops_pkg::result_src_e      result_src;
    exec_ops_pkg::alu_op_e          alu_op;
    logic                           mul_en;
    exec_ops_pkg::mul_cmd_e         mul_cmd;
    logic                           valid_out;
    logic [`EXEC_XLEN-1:0]          result_lo;
    logic [`EXEC_XLEN-1:0]          result_hi;
    logic [3:0]                     flags;

    // Model results for the item currently on the inputs.
    logic [31:0] exp_lo;
    logic [31:0] exp_hi;
    logic [3:0]  exp_flags;
    // Same, one edge later.
    logic [31:0] exp_lo_q;
    logic [31:0] exp_hi_q;
    logic [3:0]  exp_flags_q;
    logic        valid_in_q;

    integer seed;
    int     value_errors = 0;
    int     valid_errors = 0;
    int     cycle_count = 0;

    exec_stage exec_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .in1        (in1),
        .in2        (in2),
        .in3        (in3),
        .in4        (in4),
        .ext_imm    (ext_imm),
        .instr_11_4 (instr_11_4),
        .alu_src    (alu_src),
        .carry      (carry),
        .swap       (swap),
        .inv        (inv),
        .not_shift  (not_shift),
        .result_src (result_src),
        .alu_op     (alu_op),
        .mul_en     (mul_en),
        .mul_cmd    (mul_cmd),
        .valid_out  (valid_out),
        .result_lo  (result_lo),
        .result_hi  (result_hi),
        .flags      (flags)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Returns {carry, value}; field bits are [7:3] amount, [2:1] type, [0] register flag.
    function automatic logic [32:0] shift_model(input logic [31:0] x, input logic [7:0] field,
                                                input logic [31:0] rs_val, input logic c_in,
                                                input logic bypass);
        logic [1:0]  kind;
        int          n;
        int          m;
        logic [31:0] y;
        logic        c;
        kind = field[2:1];
        y = x;
        c = c_in;
        if (bypass)
            return {c, y};
        n = field[0] ? int'(rs_val[7:0]) : int'(field[7:3]);
        if (!field[0] && n == 0) begin
            if (kind == exec_ops_pkg::SH_LSR || kind == exec_ops_pkg::SH_ASR)
                n = 32;
            else if (kind == exec_ops_pkg::SH_ROR)
                return {x[0], c_in, x[31:1]};
        end
        if (n == 0)
            return {c, y};
        case (kind)
            exec_ops_pkg::SH_LSL: begin
                y = (n < 32) ? x << n : 32'h0;
                c = (n < 32) ? x[32-n] : ((n == 32) ? x[0] : 1'b0);
            end
            exec_ops_pkg::SH_LSR: begin
                y = (n < 32) ? x >> n : 32'h0;
                c = (n < 32) ? x[n-1] : ((n == 32) ? x[31] : 1'b0);
            end
            exec_ops_pkg::SH_ASR: begin
                if (n < 32)
                    y = $signed(x) >>> n;
                else
                    y = {32{x[31]}};
                c = (n < 32) ? x[n-1] : x[31];
            end
            default: begin
                m = n % 32;
                if (m != 0)
                    y = (x >> m) | (x << (32 - m));
                c = y[31];
            end
        endcase
        return {c, y};
    endfunction

    task automatic compute_expected();
        logic [32:0] sh;
        logic [31:0] op_b;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] alu_res;
        logic [31:0] mux;
        logic [63:0] sum;
        logic [63:0] uprod;
        logic [63:0] sprod;
        logic [63:0] total;
        longint      ssum;
        logic        cin;
        logic        alu_c;
        logic        alu_v;
        logic        is_add;
        logic        long_mul;
        sh    = shift_model(in2, instr_11_4, in4, carry, not_shift);
        op_b  = alu_src ? ext_imm : sh[31:0];
        a     = swap ? op_b : in1;
        b     = swap ? in1 : op_b;
        b     = inv ? ~b : b;
        is_add = (alu_op == exec_ops_pkg::ALU_ADD) || (alu_op == exec_ops_pkg::ALU_ADD_ONE) ||
                 (alu_op == exec_ops_pkg::ALU_ADC);
        cin   = (alu_op == exec_ops_pkg::ALU_ADD_ONE) ||
                ((alu_op == exec_ops_pkg::ALU_ADC) && carry);
        sum   = {32'h0, a} + {32'h0, b} + {63'h0, cin};
        ssum  = longint'($signed(a)) + longint'($signed(b)) + longint'(cin);
        alu_c = 1'b0;
        alu_v = 1'b0;
        case (alu_op)
            exec_ops_pkg::ALU_AND: alu_res = a & b;
            exec_ops_pkg::ALU_ORR: alu_res = a | b;
            exec_ops_pkg::ALU_EOR: alu_res = a ^ b;
            default:               alu_res = is_add ? sum[31:0] : 32'h0;
        endcase
        if (is_add) begin
            alu_c = sum[32];
            // Overflow when the true signed sum does not fit in 32 bits.
            alu_v = (ssum != longint'($signed(alu_res)));
        end
        case (result_src)
            exec_ops_pkg::RES_ALU:   mux = alu_res;
            exec_ops_pkg::RES_SRC_B: mux = b;
            default:                 mux = in1;
        endcase

        uprod    = {32'h0, in2} * {32'h0, in4};
        sprod    = longint'($signed(in2)) * longint'($signed(in4));
        long_mul = 1'b1;
        case (mul_cmd)
            exec_ops_pkg::MUL_UMULL: total = uprod;
            exec_ops_pkg::MUL_UMLAL: total = uprod + {in3, in1};
            exec_ops_pkg::MUL_SMULL: total = sprod;
            exec_ops_pkg::MUL_SMLAL: total = sprod + {in3, in1};
            exec_ops_pkg::MUL_MUL: begin
                total    = {32'h0, uprod[31:0]};
                long_mul = 1'b0;
            end
            exec_ops_pkg::MUL_MLA: begin
                total    = {32'h0, uprod[31:0] + in1};
                long_mul = 1'b0;
            end
            default: begin
                total    = 64'h0;
                long_mul = 1'b0;
            end
        endcase

        if (mul_en) begin
            exp_lo = total[31:0];
            exp_hi = total[63:32];
            if (long_mul)
                exp_flags = {total[63], total == 64'h0, 2'b00};
            else
                exp_flags = {total[31], total[31:0] == 32'h0, 2'b00};
        end else begin
            exp_lo = mux;
            exp_hi = alu_res;
            if (is_add && result_src == exec_ops_pkg::RES_ALU)
                exp_flags = {mux[31], mux == 32'h0, alu_c, alu_v};
            else
                exp_flags = {mux[31], mux == 32'h0, sh[32], 1'b0};
        end
    endtask

    // Random operands and controls shared by every item; about one in four is a gap.
    task automatic randomize_item();
        logic [31:0] r;
        in1        = $random(seed);
        in2        = $random(seed);
        in3        = $random(seed);
        in4        = $random(seed);
        ext_imm    = $random(seed);
        r          = $random(seed);
        instr_11_4 = r[7:0];
        alu_src    = r[8];
        carry      = r[9];
        swap       = r[10];
        inv        = r[11];
        not_shift  = r[12];
        result_src = exec_ops_pkg::result_src_e'(r[14:13]);
        alu_op     = exec_ops_pkg::alu_op_e'(r[17:15]);
        mul_cmd    = exec_ops_pkg::mul_cmd_e'(r[20:18]);
        valid_in   = (r[22:21] != 2'b00);
        mul_en     = 1'b0;
    endtask

    task automatic drive_shift_item();
        logic [31:0] r;
        randomize_item();
        r       = $random(seed);
        alu_src = 1'b0;
        // Register form keeps instruction bit 7 clear.
        if (instr_11_4.reg_form.reg_flag)
            instr_11_4.reg_form.zero = 1'b0;
        case (r[2:0])
            3'd0:    in4[7:0] = 8'd0;
            3'd1:    in4[7:0] = 8'd31;
            3'd2:    in4[7:0] = 8'd32;
            3'd3:    in4[7:0] = 8'd33;
            3'd4:    in4[7:0] = 8'd255;
            default: ;
        endcase
        not_shift = (r[4:3] == 2'b00);
    endtask

    task automatic drive_mul_item();
        logic [31:0] r;
        randomize_item();
        r      = $random(seed);
        mul_en = 1'b1;
        // Zero operands now and then so the 64-bit Z flag gets set.
        if (r[2:0] == 3'd0) begin
            in2 = 32'h0;
            in1 = 32'h0;
            in3 = 32'h0;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_in_q  <= 1'b0;
            exp_lo_q    <= '0;
            exp_hi_q    <= '0;
            exp_flags_q <= '0;
        end else begin
            valid_in_q <= valid_in;
            if (valid_in) begin
                exp_lo_q    <= exp_lo;
                exp_hi_q    <= exp_hi;
                exp_flags_q <= exp_flags;
            end
        end
    end

    // Outputs are settled at the falling edge.
    always @(negedge clk) begin
        if (valid_out !== valid_in_q) begin
            $display("valid_out is %b but valid_in was %b on the previous edge, at %0t",
                     valid_out, valid_in_q, $time);
            valid_errors++;
        end
        if (result_lo !== exp_lo_q) begin
            $display("ERROR result_lo: got %h, expected %h", result_lo, exp_lo_q);
            value_errors++;
        end
        if (result_hi !== exp_hi_q) begin
            $display("ERROR result_hi: got %h, expected %h", result_hi, exp_hi_q);
            value_errors++;
        end
        if (flags !== exp_flags_q) begin
            $display("ERROR flags: got %h, expected %h", flags, exp_flags_q);
            value_errors++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("The run did not finish within %0d cycles and was stopped.", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        seed       = 32'hc7e0_43e2;
        rst_n      = 1'b0;
        valid_in   = 1'b0;
        in1        = '0;
        in2        = '0;
        in3        = '0;
        in4        = '0;
        ext_imm    = '0;
        instr_11_4 = '0;
        alu_src    = 1'b0;
        carry      = 1'b0;
        swap       = 1'b0;
        inv        = 1'b0;
        not_shift  = 1'b0;
        result_src = exec_ops_pkg::RES_ALU;
        alu_op     = exec_ops_pkg::ALU_ADD;
        mul_en     = 1'b0;
        mul_cmd    = exec_ops_pkg::MUL_MUL;
        compute_expected();
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        for (int i = 0; i < N_ALU; i++) begin
            @(posedge clk);
            #10;
            randomize_item();
            compute_expected();
        end
        for (int i = 0; i < N_SHIFT; i++) begin
            @(posedge clk);
            #10;
            drive_shift_item();
            compute_expected();
        end
        for (int i = 0; i < N_MUL; i++) begin
            @(posedge clk);
            #10;
            drive_mul_item();
            compute_expected();
        end
        // ALU and multiply items alternate with no gaps.
        for (int i = 0; i < N_MIX; i++) begin
            @(posedge clk);
            #10;
            if (i % 2 == 0)
                randomize_item();
            else
                drive_mul_item();
            valid_in = 1'b1;
            compute_expected();
        end

        @(posedge clk);
        #10;
        valid_in = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        #1;
        $display("Value errors: %0d, valid errors: %0d", value_errors, valid_errors);
        if (value_errors == 0 && valid_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
